// ==== holdCtrl.f ====
+incdir+include
design/holdCtrlPkg.sv
design/holdCtrlRegs.sv
design/trigEdgeDetect.sv
design/holdPulseGen.sv
design/razPulseGen.sv
design/holdCtrlTop.sv
verif/holdCtrlTb.sv

// ==== Makefile ====
# Verilator build and run for the hold controller testbench

VERILATOR ?= verilator
TOP       ?= holdCtrlTb
FILELIST  ?= holdCtrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, pass only if the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/holdCtrlTb.sv ====
`include "holdCtrl_defs.svh"

module holdCtrlTb import holdCtrlPkg::*; ();

  // worst case of every hold and raz sequence run below, times 20
  localparam int HoldSeqMax = 2 + (1 << `HOLD_DELAY_W) + 32 + 8;
  localparam int RazSeqMax  = 2 + (1 << `RAZ_DELAY_W) + `RAZ_WIDTH + 1 + 8;
  localparam int CycleLimit = 20 * (10 * HoldSeqMax + 4 * RazSeqMax);

  logic                   Clk;
  logic                   reset_n;
  logic                   PSEL;
  logic                   PENABLE;
  logic                   PWRITE;
  logic [`APB_ADDR_W-1:0] PADDR;
  logic [`APB_DATA_W-1:0] PWDATA;
  logic [`APB_DATA_W-1:0] PRDATA;
  logic                   PREADY;
  logic                   PSLVERR;
  logic [3:0]             trigB; // index follows trigSel, bit 3 is external
  logic                   HOLD;
  logic                   SingleRaz_en;

  int     cycle = 0;
  int     errorCount = 0;
  int     checkCount = 0;
  integer seed = 42582;
  // expectations handed from the stimulus to the comparing process
  int     holdExpect = 0;
  int     expHoldStart;
  int     expHoldWidth;
  int     razExpect = 0;
  int     expRazStart;
  int     expRazWidth;
  int     holdPulses = 0;
  int     holdRise;
  int     razRise;
  logic   holdPrev = 1'b0;
  logic   razPrev = 1'b0;

  holdCtrlTop dut_i (
    .Clk, .reset_n,
    .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .PRDATA, .PREADY, .PSLVERR,
    .OUT_TRIG0B(trigB[0]), .OUT_TRIG1B(trigB[1]), .OUT_TRIG2B(trigB[2]), .Ext_TRIGB(trigB[3]),
    .HOLD, .SingleRaz_en
  );

  initial begin
    Clk = 1'b0;
    forever #2 Clk = ~Clk;
  end

  always @(posedge Clk) cycle <= cycle + 1; // rising edges seen so far

  task automatic checkValue(input int got, input int exp, input string what);
    checkCount++;
    if (got != exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // E+1 to leave the synchroniser, one more to leave idle, then the delay count
  function automatic void predictPulse(input int edgeCyc, input int delay, input int widthLimit,
                                       output int startCyc, output int width);
    startCyc = edgeCyc + 2 + delay;
    width    = widthLimit + 1;
  endfunction

  function automatic logic [31:0] ctrlWord(input logic holdOn, input logic razOn,
                                           input trigSel_t sel);
    return {28'd0, sel, razOn, holdOn};
  endfunction

  task automatic apbWrite(input logic [`APB_ADDR_W-1:0] addr,
                          input logic [`APB_DATA_W-1:0] data, output logic slvErr);
    @(negedge Clk);
    PSEL    = 1'b1; // setup phase
    PENABLE = 1'b0;
    PWRITE  = 1'b1;
    PADDR   = addr;
    PWDATA  = data;
    @(negedge Clk);
    PENABLE = 1'b1;
    #1;
    slvErr = PSLVERR; // write lands on the next rising edge
    @(negedge Clk);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic apbRead(input logic [`APB_ADDR_W-1:0] addr,
                         output logic [`APB_DATA_W-1:0] data, output logic slvErr);
    @(negedge Clk);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = addr;
    @(negedge Clk);
    PENABLE = 1'b1;
    #1;
    data   = PRDATA;
    slvErr = PSLVERR;
    @(negedge Clk);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  // pull the masked lines low, E is the next rising edge
  task automatic fireTrigger(input logic [3:0] mask, output int edgeCyc);
    @(negedge Clk);
    trigB   = trigB & ~mask;
    edgeCyc = cycle + 1;
  endtask

  task automatic releaseTriggers(input int lowCycles);
    repeat (lowCycles) @(negedge Clk);
    trigB = 4'hF;
  endtask

  task automatic reportAndFinish(input bit timedOut);
    $display("checks: %0d  errors: %0d", checkCount, errorCount);
    if (errorCount == 0 && !timedOut) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  // records rise and fall cycles, compares against the predicted pulse
  always @(negedge Clk) begin
    if (HOLD && !holdPrev) begin
      holdRise = cycle;
      holdPulses++;
    end else if (!HOLD && holdPrev) begin
      if (holdExpect == 0) begin
        errorCount++;
        $display("unexpected HOLD pulse, it rose at cycle %0d", holdRise);
      end else begin
        checkValue(holdRise, expHoldStart, "HOLD rise cycle");
        checkValue(cycle - holdRise, expHoldWidth, "HOLD width");
        holdExpect--;
      end
    end
    if (SingleRaz_en && !razPrev) begin
      razRise = cycle;
    end else if (!SingleRaz_en && razPrev) begin
      if (razExpect == 0) begin
        errorCount++;
        $display("unexpected SingleRaz_en pulse, it rose at cycle %0d", razRise);
      end else begin
        checkValue(razRise, expRazStart, "SingleRaz_en rise cycle");
        checkValue(cycle - razRise, expRazWidth, "SingleRaz_en width");
        razExpect--;
      end
    end
    holdPrev = HOLD;
    razPrev  = SingleRaz_en;
  end

  initial begin
    wait (cycle >= CycleLimit);
    $display("timeout: the run went past %0d cycles without finishing", CycleLimit);
    reportAndFinish(1'b1);
  end

  initial begin
    logic [`APB_DATA_W-1:0] rdata;
    logic                   slvErr;
    regAddr_t               addr;
    int                     edgeCyc;
    int                     holdDly;
    int                     holdTm;
    int                     razDly;
    int                     line;

    reset_n = 1'b0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    trigB   = 4'hF; // triggers idle high
    repeat (10) @(negedge Clk);
    reset_n = 1'b1;

    // reset values, readback, bad accesses
    checkValue(int'(HOLD), 0, "HOLD after reset");
    checkValue(int'(SingleRaz_en), 0, "SingleRaz_en after reset");
    checkValue(int'(PREADY), 1, "PREADY");
    addr = addr.first();
    repeat (addr.num()) begin
      apbRead(addr, rdata, slvErr);
      checkValue(int'(rdata), 0, $sformatf("reset value at 0x%02h", addr));
      addr = addr.next();
    end
    apbWrite(REG_CTRL, 32'hD, slvErr);
    apbWrite(REG_HOLD_DELAY, 32'h1A5, slvErr);
    apbWrite(REG_HOLD_TIME, 32'hBEEF, slvErr);
    apbWrite(REG_RAZ_DELAY, 32'h2C3, slvErr);
    apbRead(REG_CTRL, rdata, slvErr);
    checkValue(int'(rdata), 'hD, "CTRL readback");
    apbRead(REG_HOLD_DELAY, rdata, slvErr);
    checkValue(int'(rdata), 'h1A5, "HOLD_DELAY readback");
    apbRead(REG_HOLD_TIME, rdata, slvErr);
    checkValue(int'(rdata), 'hBEEF, "HOLD_TIME readback");
    apbRead(REG_RAZ_DELAY, rdata, slvErr);
    checkValue(int'(rdata), 'h2C3, "RAZ_DELAY readback");
    checkValue(int'(slvErr), 0, "PSLVERR on a good read");
    apbRead(8'h18, rdata, slvErr);
    checkValue(int'(slvErr), 1, "PSLVERR on unmapped read");
    apbWrite(REG_STATUS, 32'h3, slvErr);
    checkValue(int'(slvErr), 1, "PSLVERR on STATUS write");

    // each source, unselected lines first
    for (int s = 0; s < 4; s++) begin
      holdDly = $unsigned($random(seed)) % 512;
      holdTm  = $unsigned($random(seed)) % 32;
      apbWrite(REG_HOLD_DELAY, 32'(holdDly), slvErr);
      apbWrite(REG_HOLD_TIME, 32'(holdTm), slvErr);
      apbWrite(REG_CTRL, ctrlWord(1'b1, 1'b0, trigSel_t'(2'(s))), slvErr);
      fireTrigger(~(4'b0001 << s), edgeCyc);
      releaseTriggers(3);
      repeat (holdDly + holdTm + 8) @(negedge Clk);
      fireTrigger(4'b0001 << s, edgeCyc);
      predictPulse(edgeCyc, holdDly, holdTm, expHoldStart, expHoldWidth);
      holdExpect = 1;
      releaseTriggers(3);
      wait (holdExpect == 0);
    end

    // hold disabled, then a second edge while busy
    apbWrite(REG_CTRL, ctrlWord(1'b0, 1'b0, TRIG0), slvErr);
    fireTrigger(4'b0001, edgeCyc);
    releaseTriggers(3);
    repeat (holdDly + holdTm + 8) @(negedge Clk);
    apbWrite(REG_HOLD_DELAY, 32'd20, slvErr);
    apbWrite(REG_HOLD_TIME, 32'd20, slvErr);
    apbWrite(REG_CTRL, ctrlWord(1'b1, 1'b0, TRIG_EXT), slvErr);
    fireTrigger(4'b1000, edgeCyc);
    predictPulse(edgeCyc, 20, 20, expHoldStart, expHoldWidth);
    holdExpect = 1;
    releaseTriggers(3);
    apbRead(REG_STATUS, rdata, slvErr);
    checkValue(int'(rdata & 32'h1), 1, "STATUS holdBusy mid-sequence");
    fireTrigger(4'b1000, edgeCyc); // ignored, no retrigger
    releaseTriggers(3);
    wait (holdExpect == 0);
    repeat (51) @(negedge Clk);

    // raz path on single discriminators
    apbWrite(REG_CTRL, ctrlWord(1'b0, 1'b1, TRIG0), slvErr);
    repeat (3) begin
      razDly = $unsigned($random(seed)) % 1024;
      line   = $unsigned($random(seed)) % 3;
      apbWrite(REG_RAZ_DELAY, 32'(razDly), slvErr);
      fireTrigger(4'b0001 << line, edgeCyc);
      predictPulse(edgeCyc, razDly, `RAZ_WIDTH, expRazStart, expRazWidth);
      razExpect = 1;
      releaseTriggers(3);
      apbRead(REG_STATUS, rdata, slvErr);
      checkValue(int'(rdata[1]), 1, "STATUS razBusy mid-sequence");
      wait (razExpect == 0);
    end
    apbWrite(REG_CTRL, ctrlWord(1'b0, 1'b0, TRIG0), slvErr);
    fireTrigger(4'b0111, edgeCyc);
    releaseTriggers(3);
    repeat (razDly + `RAZ_WIDTH + 8) @(negedge Clk);

    // event counter and its clear
    apbRead(REG_HOLD_CNT, rdata, slvErr);
    checkValue(int'(rdata), holdPulses, "HOLD_CNT against counted pulses");
    apbWrite(REG_HOLD_CNT, 32'hFFFF, slvErr);
    checkValue(int'(slvErr), 0, "PSLVERR on HOLD_CNT clear");
    apbRead(REG_HOLD_CNT, rdata, slvErr);
    checkValue(int'(rdata), 0, "HOLD_CNT after clear");

    reportAndFinish(1'b0);
  end

endmodule

// ==== design/holdCtrlTop.sv ====
`include "holdCtrl_defs.svh"

module holdCtrlTop import holdCtrlPkg::*; (
  input  logic                   Clk,
  input  logic                   reset_n,
  input  logic                   PSEL,
  input  logic                   PENABLE,
  input  logic                   PWRITE,
  input  logic [`APB_ADDR_W-1:0] PADDR,
  input  logic [`APB_DATA_W-1:0] PWDATA,
  output logic [`APB_DATA_W-1:0] PRDATA,
  output logic                   PREADY,
  output logic                   PSLVERR,
  input  logic                   OUT_TRIG0B,
  input  logic                   OUT_TRIG1B,
  input  logic                   OUT_TRIG2B,
  input  logic                   Ext_TRIGB,
  output logic                   HOLD,
  output logic                   SingleRaz_en
);

  trigSel_t                 trigSel;
  logic                     holdEn;
  logic                     razEn;
  logic [`HOLD_DELAY_W-1:0] holdDelay;
  logic [`HOLD_TIME_W-1:0]  holdTime;
  logic [`RAZ_DELAY_W-1:0]  razDelay;
  logic                     coincFall;
  logic                     andFall;
  logic                     holdBusy;
  logic                     holdStart;
  logic                     razBusy;

  holdCtrlRegs regs_i (
    .Clk, .reset_n,
    .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .PRDATA, .PREADY, .PSLVERR,
    .holdBusy, .razBusy, .holdStart,
    .trigSel, .holdEn, .razEn,
    .holdDelay, .holdTime, .razDelay
  );

  trigEdgeDetect edge_i (
    .Clk, .reset_n,
    .trigSel, .razEn,
    .OUT_TRIG0B, .OUT_TRIG1B, .OUT_TRIG2B, .Ext_TRIGB,
    .coincFall, .andFall
  );

  holdPulseGen hold_i (
    .Clk, .reset_n,
    .coincFall, .holdEn, .holdDelay, .holdTime,
    .HOLD, .holdBusy, .holdStart
  );

  razPulseGen raz_i (
    .Clk, .reset_n,
    .andFall, .razDelay,
    .SingleRaz_en, .razBusy
  );

endmodule

// ==== design/razPulseGen.sv ====
`include "holdCtrl_defs.svh"

module razPulseGen import holdCtrlPkg::*; (
  input  logic                    Clk,
  input  logic                    reset_n,
  input  logic                    andFall,
  input  logic [`RAZ_DELAY_W-1:0] razDelay,
  output logic                    SingleRaz_en,
  output logic                    razBusy
);

  localparam int WidthW = $clog2(`RAZ_WIDTH + 1);

  razState_t               state;
  logic [`RAZ_DELAY_W-1:0] delayCnt;
  logic [WidthW-1:0]       widthCnt;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state        <= RAZ_IDLE;
      delayCnt     <= '0;
      widthCnt     <= '0;
      SingleRaz_en <= 1'b0;
    end else begin
      case (state)
        RAZ_IDLE: begin
          if (andFall) begin
            state <= RAZ_DELAY;
          end
        end
        RAZ_DELAY: begin
          if (delayCnt < razDelay) begin
            delayCnt <= delayCnt + 1'b1;
          end else begin
            delayCnt     <= '0;
            SingleRaz_en <= 1'b1;
            state        <= RAZ_ACTIVE;
          end
        end
        RAZ_ACTIVE: begin
          // must outlast one readout clock period
          if (widthCnt < WidthW'(`RAZ_WIDTH)) begin
            widthCnt <= widthCnt + 1'b1;
          end else begin
            widthCnt     <= '0;
            SingleRaz_en <= 1'b0;
            state        <= RAZ_IDLE;
          end
        end
        default: state <= RAZ_IDLE;
      endcase
    end
  end

  assign razBusy = (state != RAZ_IDLE);

endmodule

// ==== design/holdPulseGen.sv ====
`include "holdCtrl_defs.svh"

module holdPulseGen import holdCtrlPkg::*; (
  input  logic                     Clk,
  input  logic                     reset_n,
  input  logic                     coincFall,
  input  logic                     holdEn,
  input  logic [`HOLD_DELAY_W-1:0] holdDelay,
  input  logic [`HOLD_TIME_W-1:0]  holdTime,
  output logic                     HOLD,      // freezes the analogue output
  output logic                     holdBusy,
  output logic                     holdStart
);

  holdState_t               state;
  logic [`HOLD_DELAY_W-1:0] delayCnt;
  logic [`HOLD_TIME_W-1:0]  widthCnt;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= HOLD_IDLE;
      delayCnt  <= '0;
      widthCnt  <= '0;
      HOLD      <= 1'b0;
      holdStart <= 1'b0;
    end else begin
      holdStart <= 1'b0; // single cycle strobe
      case (state)
        HOLD_IDLE: begin
          if (coincFall && holdEn) begin
            state <= HOLD_DELAY;
          end
        end
        HOLD_DELAY: begin
          if (delayCnt < holdDelay) begin
            delayCnt <= delayCnt + 1'b1;
          end else begin
            delayCnt  <= '0;
            HOLD      <= 1'b1;
            holdStart <= 1'b1;
            state     <= HOLD_ACTIVE;
          end
        end
        HOLD_ACTIVE: begin
          // holdTime+1 cycles high
          if (widthCnt < holdTime) begin
            widthCnt <= widthCnt + 1'b1;
          end else begin
            widthCnt <= '0;
            HOLD     <= 1'b0;
            state    <= HOLD_IDLE;
          end
        end
        default: state <= HOLD_IDLE;
      endcase
    end
  end

  // edges seen while busy are dropped
  assign holdBusy = (state != HOLD_IDLE);

endmodule

// ==== design/trigEdgeDetect.sv ====
`include "holdCtrl_defs.svh"

module trigEdgeDetect import holdCtrlPkg::*; (
  input  logic     Clk,
  input  logic     reset_n,
  input  trigSel_t trigSel,
  input  logic     razEn,
  input  logic     OUT_TRIG0B, // discriminator triggers, active low
  input  logic     OUT_TRIG1B,
  input  logic     OUT_TRIG2B,
  input  logic     Ext_TRIGB,  // external trigger, active low
  output logic     coincFall,
  output logic     andFall
);

  logic coincSrc;
  logic coincSync1;
  logic coincSync2;
  logic trigAnd;
  logic andSync1;
  logic andSync2;

  always_comb begin
    case (trigSel)
      TRIG0:   coincSrc = OUT_TRIG0B;
      TRIG1:   coincSrc = OUT_TRIG1B;
      TRIG2:   coincSrc = OUT_TRIG2B;
      default: coincSrc = Ext_TRIGB;
    endcase
  end

  // low as soon as any discriminator fires
  assign trigAnd = OUT_TRIG0B & OUT_TRIG1B & OUT_TRIG2B;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      coincSync1 <= 1'b1; // idle level is high
      coincSync2 <= 1'b1;
    end else begin
      coincSync1 <= coincSrc;
      coincSync2 <= coincSync1;
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      andSync1 <= 1'b1;
      andSync2 <= 1'b1;
    end else if (razEn) begin
      andSync1 <= trigAnd;
      andSync2 <= andSync1;
    end else begin
      andSync1 <= 1'b1; // parked high, no edges while disabled
      andSync2 <= 1'b1;
    end
  end

  assign coincFall = coincSync2 & ~coincSync1;
  assign andFall   = andSync2 & ~andSync1;

endmodule

// ==== design/holdCtrlRegs.sv ====
`include "holdCtrl_defs.svh"

module holdCtrlRegs import holdCtrlPkg::*; (
  input  logic                     Clk,
  input  logic                     reset_n,
  // apb slave
  input  logic                     PSEL,
  input  logic                     PENABLE,
  input  logic                     PWRITE,
  input  logic [`APB_ADDR_W-1:0]   PADDR,
  input  logic [`APB_DATA_W-1:0]   PWDATA,
  output logic [`APB_DATA_W-1:0]   PRDATA,
  output logic                     PREADY,
  output logic                     PSLVERR,
  // status from the generators
  input  logic                     holdBusy,
  input  logic                     razBusy,
  input  logic                     holdStart,
  // configuration out
  output trigSel_t                 trigSel,
  output logic                     holdEn,
  output logic                     razEn,
  output logic [`HOLD_DELAY_W-1:0] holdDelay,
  output logic [`HOLD_TIME_W-1:0]  holdTime,
  output logic [`RAZ_DELAY_W-1:0]  razDelay
);

  regAddr_t                 addr;
  logic                     access;
  logic                     wrOk;
  logic                     addrHit;
  logic                     cntClear;
  logic [`HOLD_CNT_W-1:0]   holdCnt;
  logic [`APB_DATA_W-1:0]   rdData;

  assign addr   = regAddr_t'(PADDR);
  assign access = PSEL & PENABLE; // access phase, no wait states
  assign PREADY = 1'b1;

  // read mux and address decode
  always_comb begin
    rdData  = '0;
    addrHit = 1'b1;
    case (addr)
      REG_CTRL: begin
        rdData[0]   = holdEn;
        rdData[1]   = razEn;
        rdData[3:2] = trigSel;
      end
      REG_HOLD_DELAY: rdData[`HOLD_DELAY_W-1:0] = holdDelay;
      REG_HOLD_TIME:  rdData[`HOLD_TIME_W-1:0]  = holdTime;
      REG_RAZ_DELAY:  rdData[`RAZ_DELAY_W-1:0]  = razDelay;
      REG_STATUS: begin
        rdData[0] = holdBusy;
        rdData[1] = razBusy;
      end
      REG_HOLD_CNT:   rdData[`HOLD_CNT_W-1:0] = holdCnt;
      default:        addrHit = 1'b0;
    endcase
  end

  assign PRDATA = rdData;

  // status is read only, any write to HOLD_CNT is a clear
  assign PSLVERR  = access & (~addrHit | (PWRITE & (addr == REG_STATUS)));
  assign wrOk     = access & PWRITE & ~PSLVERR;
  assign cntClear = wrOk & (addr == REG_HOLD_CNT);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      holdEn    <= 1'b0;
      razEn     <= 1'b0;
      trigSel   <= TRIG0;
      holdDelay <= '0;
      holdTime  <= '0;
      razDelay  <= '0;
    end else if (wrOk) begin
      case (addr)
        REG_CTRL: begin
          holdEn  <= PWDATA[0];
          razEn   <= PWDATA[1];
          trigSel <= trigSel_t'(PWDATA[3:2]);
        end
        REG_HOLD_DELAY: holdDelay <= PWDATA[`HOLD_DELAY_W-1:0];
        REG_HOLD_TIME:  holdTime  <= PWDATA[`HOLD_TIME_W-1:0];
        REG_RAZ_DELAY:  razDelay  <= PWDATA[`RAZ_DELAY_W-1:0];
        default: ; // counter clear handled below
      endcase
    end
  end

  // hold event counter, sticks at all ones
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      holdCnt <= '0;
    end else if (cntClear) begin
      holdCnt <= '0;
    end else if (holdStart && (holdCnt != '1)) begin
      holdCnt <= holdCnt + 1'b1;
    end
  end

endmodule

// ==== design/holdCtrlPkg.sv ====
`include "holdCtrl_defs.svh"

package holdCtrlPkg;

  // coincidence trigger source, matches CTRL[3:2]
  typedef enum logic [1:0] {
    TRIG0    = 2'b00,
    TRIG1    = 2'b01,
    TRIG2    = 2'b10,
    TRIG_EXT = 2'b11 // external trigger from the connector
  } trigSel_t;

  typedef enum logic [1:0] {
    HOLD_IDLE   = 2'b00,
    HOLD_DELAY  = 2'b01,
    HOLD_ACTIVE = 2'b10
  } holdState_t;

  typedef enum logic [1:0] {
    RAZ_IDLE   = 2'b00,
    RAZ_DELAY  = 2'b01,
    RAZ_ACTIVE = 2'b10
  } razState_t;

  typedef enum logic [`APB_ADDR_W-1:0] {
    REG_CTRL       = `ADDR_CTRL,
    REG_HOLD_DELAY = `ADDR_HOLD_DELAY,
    REG_HOLD_TIME  = `ADDR_HOLD_TIME,
    REG_RAZ_DELAY  = `ADDR_RAZ_DELAY,
    REG_STATUS     = `ADDR_STATUS,
    REG_HOLD_CNT   = `ADDR_HOLD_CNT
  } regAddr_t;

endpackage

// ==== include/holdCtrl_defs.svh ====
`ifndef HOLDCTRL_DEFS_SVH
`define HOLDCTRL_DEFS_SVH

// hold path counter widths
`define HOLD_DELAY_W 9
`define HOLD_TIME_W  16

// raz path
`define RAZ_DELAY_W 10
`define RAZ_WIDTH   16 // count limit, pulse is one cycle longer

// apb bus
`define APB_ADDR_W 8
`define APB_DATA_W 32

`define HOLD_CNT_W 16

// register byte addresses
`define ADDR_CTRL       8'h00
`define ADDR_HOLD_DELAY 8'h04
`define ADDR_HOLD_TIME  8'h08
`define ADDR_RAZ_DELAY  8'h0C
`define ADDR_STATUS     8'h10
`define ADDR_HOLD_CNT   8'h14

`endif
